// ==== source/sap_pkg.sv ====
`default_nettype none

package sap_pkg;

    localparam int DATA_W    = 12;   // Data word width.
    localparam int ADDR_W    = 8;    // Address width.
    localparam int MEM_DEPTH = 256;  // Program memory words.

    typedef logic [DATA_W-1:0] word_t;
    typedef logic [ADDR_W-1:0] addr_t;

    // Upper nibble of an instruction word.
    typedef enum logic [3:0] {
        OP_LDA = 4'd0,   // Acc = mem.
        OP_STA = 4'd1,   // Mem = acc.
        OP_ADD = 4'd2,
        OP_SUB = 4'd3,
        OP_AND = 4'd4,
        OP_IOR = 4'd5,
        OP_XOR = 4'd6,
        OP_NOR = 4'd7,
        OP_JMP = 4'd8,
        OP_JAM = 4'd9,   // Jump if minus.
        OP_JAZ = 4'd10,  // Jump if zero.
        OP_CAL = 4'd11,  // Call, one level deep.
        OP_OPR = 4'd15   // Operate group, low byte selects.
    } opcode_e;

    // Low byte of an OPR instruction.
    typedef enum logic [7:0] {
        OPR_NOP = 8'h00,
        OPR_CMA = 8'h01,  // Complement acc.
        OPR_CLA = 8'h02,  // Clear acc.
        OPR_RET = 8'h03,  // Return from call.
        OPR_INP = 8'h04,  // Acc = input register.
        OPR_OUT = 8'h05,  // Acc to output port.
        OPR_HLT = 8'h06
    } opr_e;

    typedef struct packed {
        opcode_e opcode;
        addr_t   operand;
    } instr_t;

    typedef enum logic [3:0] {
        ALU_PASS_B = 4'd0,
        ALU_ADD    = 4'd1,
        ALU_SUB    = 4'd2,
        ALU_AND    = 4'd3,
        ALU_IOR    = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_NOR    = 4'd6,
        ALU_CMA    = 4'd7,
        ALU_CLA    = 4'd8
    } alu_op_e;

    typedef enum logic [1:0] {
        ACC_SRC_ALU = 2'd0,
        ACC_SRC_IN  = 2'd1
    } acc_src_e;

    typedef struct packed {
        logic     mar_load;     // Load MAR this cycle.
        logic     mar_from_pc;  // MAR source, PC else operand.
        logic     mem_write;    // Store acc at MAR.
        logic     acc_load;
        acc_src_e acc_src;
        alu_op_e  alu_op;
        logic     out_load;     // Capture acc into output reg.
    } ctrl_t;

    localparam ctrl_t CTRL_NONE = '0;  // All strobes off.

    typedef struct packed {
        logic minus;
        logic zero;
    } flags_t;

    typedef struct packed {
        addr_t addr;
        word_t data;
    } load_req_t;

endpackage

`default_nettype wire

// ==== source/program_loader.sv ====
`default_nettype none

module program_loader (
    input  wire                clk,
    input  wire                rst,
    input  wire                load_valid,
    input  wire sap_pkg::load_req_t load_req,
    input  wire                run,
    input  wire                in_valid,
    input  wire sap_pkg::word_t in_data,
    input  wire                halt,
    output logic               ram_we,
    output sap_pkg::load_req_t ram_req,
    output logic               start,
    output sap_pkg::word_t     in_word,
    output logic               running,
    output logic               halted
);

    // Run only counts while idle.
    assign start = run && !running;

    // Program is frozen while it executes.
    assign ram_we  = load_valid && !running;
    assign ram_req = load_req;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            running <= 1'b0;
            halted  <= 1'b0;
        end else if (start) begin
            running <= 1'b1;
            halted  <= 1'b0;  // Fresh run clears halted.
        end else if (halt) begin
            running <= 1'b0;
            halted  <= 1'b1;
        end
    end

    // Input register, last word wins.
    always_ff @(posedge clk) begin
        if (in_valid) begin
            in_word <= in_data;
        end
    end

endmodule

`default_nettype wire

// ==== source/memory_unit.sv ====
`default_nettype none

module memory_unit (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     running,
    input  wire                     ext_we,
    input  wire sap_pkg::load_req_t ext_req,
    input  wire sap_pkg::ctrl_t     ctrl,
    input  wire sap_pkg::addr_t     pc,
    input  wire sap_pkg::addr_t     operand,
    input  wire sap_pkg::word_t     acc,
    output sap_pkg::word_t          rdata
);

    sap_pkg::addr_t mar;                       // Memory address register.
    sap_pkg::word_t ram [sap_pkg::MEM_DEPTH];  // 256 x 12 program store.
    logic           we;
    sap_pkg::addr_t waddr;
    sap_pkg::word_t wdata;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mar <= '0;
        end else if (ctrl.mar_load) begin
            mar <= ctrl.mar_from_pc ? pc : operand;  // Fetch or operand address.
        end
    end

    // Write port owner follows the mode.
    always_comb begin
        if (running) begin
            we    = ctrl.mem_write;  // STA.
            waddr = mar;
            wdata = acc;
        end else begin
            we    = ext_we;          // Loader.
            waddr = ext_req.addr;
            wdata = ext_req.data;
        end
    end

    always_ff @(posedge clk) begin
        if (we) begin
            ram[waddr] <= wdata;
        end
    end

    assign rdata = ram[mar];  // Async read, feeds IR and ALU.

endmodule

`default_nettype wire

// ==== source/alu.sv ====
`default_nettype none

module alu (
    input  wire sap_pkg::alu_op_e op,
    input  wire sap_pkg::word_t   a,
    input  wire sap_pkg::word_t   b,
    output sap_pkg::word_t        y
);

    // A is the accumulator, b the memory word.
    always_comb begin
        case (op)
            sap_pkg::ALU_PASS_B: begin
                y = b;  // Load.
            end
            sap_pkg::ALU_ADD: begin
                y = a + b;  // Wraps at 12 bits.
            end
            sap_pkg::ALU_SUB: begin
                y = a - b;  // Modulo 2^12.
            end
            sap_pkg::ALU_AND: begin
                y = a & b;
            end
            sap_pkg::ALU_IOR: begin
                y = a | b;
            end
            sap_pkg::ALU_XOR: begin
                y = a ^ b;
            end
            sap_pkg::ALU_NOR: begin
                y = ~(a | b);
            end
            sap_pkg::ALU_CMA: begin
                y = ~a;  // B ignored.
            end
            sap_pkg::ALU_CLA: begin
                y = '0;
            end
            default: begin
                y = b;  // Unlisted code passes b.
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== source/sequencer.sv ====
`default_nettype none

module sequencer (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  start,
    input  wire sap_pkg::word_t  rdata,
    input  wire sap_pkg::flags_t flags,
    output sap_pkg::ctrl_t       ctrl,
    output sap_pkg::addr_t       pc,
    output sap_pkg::addr_t       operand,
    output logic                 halt
);

    typedef enum logic [2:0] {
        IDLE,
        T0,  // MAR <= PC.
        T1,  // IR <= mem, PC++.
        E0,  // Decode, jumps and OPR.
        E1   // Data op with memory operand.
    } state_e;

    state_e          state;
    state_e          state_nxt;
    sap_pkg::instr_t ir;
    sap_pkg::addr_t  ret_addr;  // Return register, one level.
    sap_pkg::opr_e   opr;
    logic            branch;    // PC takes operand in E0.

    // Memory opcode to ALU function.
    function automatic sap_pkg::alu_op_e alu_sel(input sap_pkg::opcode_e op);
        case (op)
            sap_pkg::OP_ADD: alu_sel = sap_pkg::ALU_ADD;
            sap_pkg::OP_SUB: alu_sel = sap_pkg::ALU_SUB;
            sap_pkg::OP_AND: alu_sel = sap_pkg::ALU_AND;
            sap_pkg::OP_IOR: alu_sel = sap_pkg::ALU_IOR;
            sap_pkg::OP_XOR: alu_sel = sap_pkg::ALU_XOR;
            sap_pkg::OP_NOR: alu_sel = sap_pkg::ALU_NOR;
            default:         alu_sel = sap_pkg::ALU_PASS_B;  // LDA.
        endcase
    endfunction

    assign operand = ir.operand;
    assign opr     = sap_pkg::opr_e'(ir.operand);  // OPR subcode.

    always_comb begin
        ctrl      = sap_pkg::CTRL_NONE;
        state_nxt = state;
        halt      = 1'b0;
        branch    = 1'b0;
        case (state)
            IDLE: begin
                if (start) state_nxt = T0;
            end
            T0: begin
                ctrl.mar_load    = 1'b1;
                ctrl.mar_from_pc = 1'b1;
                state_nxt        = T1;
            end
            T1: begin
                state_nxt = E0;
            end
            E0: begin
                state_nxt = T0;
                case (ir.opcode)
                    sap_pkg::OP_LDA, sap_pkg::OP_STA, sap_pkg::OP_ADD, sap_pkg::OP_SUB,
                    sap_pkg::OP_AND, sap_pkg::OP_IOR, sap_pkg::OP_XOR, sap_pkg::OP_NOR: begin
                        ctrl.mar_load = 1'b1;  // MAR <= operand.
                        state_nxt     = E1;
                    end
                    sap_pkg::OP_JMP: branch = 1'b1;
                    sap_pkg::OP_JAM: branch = flags.minus;
                    sap_pkg::OP_JAZ: branch = flags.zero;
                    sap_pkg::OP_CAL: branch = 1'b1;
                    sap_pkg::OP_OPR: begin
                        case (opr)
                            sap_pkg::OPR_CMA: begin
                                ctrl.acc_load = 1'b1;
                                ctrl.alu_op   = sap_pkg::ALU_CMA;
                            end
                            sap_pkg::OPR_CLA: begin
                                ctrl.acc_load = 1'b1;
                                ctrl.alu_op   = sap_pkg::ALU_CLA;
                            end
                            sap_pkg::OPR_INP: begin
                                ctrl.acc_load = 1'b1;
                                ctrl.acc_src  = sap_pkg::ACC_SRC_IN;
                            end
                            sap_pkg::OPR_OUT: ctrl.out_load = 1'b1;
                            sap_pkg::OPR_HLT: begin
                                halt      = 1'b1;  // One-cycle pulse to loader.
                                state_nxt = IDLE;
                            end
                            default: ;  // NOP, RET handled on the PC.
                        endcase
                    end
                    default: ;  // Codes 12 to 14 act as NOP.
                endcase
            end
            E1: begin
                state_nxt = T0;
                if (ir.opcode == sap_pkg::OP_STA) begin
                    ctrl.mem_write = 1'b1;
                end else begin
                    ctrl.acc_load = 1'b1;
                    ctrl.alu_op   = alu_sel(ir.opcode);
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= IDLE;
            pc       <= '0;
            ret_addr <= '0;
            ir       <= '0;
        end else begin
            state <= state_nxt;
            if (state == IDLE && start) begin
                pc <= '0;  // Program starts at 0.
            end
            if (state == T1) begin
                ir <= sap_pkg::instr_t'(rdata);
                pc <= pc + 1'b1;
            end
            if (state == E0) begin
                if (ir.opcode == sap_pkg::OP_CAL) ret_addr <= pc;  // Already past CAL.
                if (branch) begin
                    pc <= ir.operand;
                end else if (ir.opcode == sap_pkg::OP_OPR && opr == sap_pkg::OPR_RET) begin
                    pc <= ret_addr;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/datapath.sv ====
`default_nettype none

module datapath (
    input  wire                 clk,
    input  wire                 rst,
    input  wire sap_pkg::ctrl_t ctrl,
    input  wire sap_pkg::word_t rdata,
    input  wire sap_pkg::word_t in_word,
    output sap_pkg::word_t      acc,
    output sap_pkg::flags_t     flags,
    output logic                out_valid,
    output sap_pkg::word_t      out_data
);

    sap_pkg::word_t alu_y;    // Function result.
    sap_pkg::word_t acc_nxt;  // Selected load value.

    // Second operand comes straight from memory.
    alu u_alu (
        .op (ctrl.alu_op),
        .a  (acc),
        .b  (rdata),
        .y  (alu_y)
    );

    always_comb begin
        if (ctrl.acc_src == sap_pkg::ACC_SRC_IN) begin
            acc_nxt = in_word;  // INP.
        end else begin
            acc_nxt = alu_y;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            acc <= '0;
        end else if (ctrl.acc_load) begin
            acc <= acc_nxt;
        end
    end

    // Flags track the accumulator every cycle.
    always_comb begin
        flags.minus = acc[sap_pkg::DATA_W-1];  // Sign bit.
        flags.zero  = (acc == '0);
    end

    // Strobe lands the cycle after OUT.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= ctrl.out_load;
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.out_load) begin
            out_data <= acc;  // Held until next OUT.
        end
    end

endmodule

`default_nettype wire

// ==== source/sap2_mini.sv ====
`default_nettype none

module sap2_mini (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     load_valid,
    input  wire sap_pkg::load_req_t load_req,
    input  wire                     run,
    input  wire                     in_valid,
    input  wire sap_pkg::word_t     in_data,
    output logic                    out_valid,
    output sap_pkg::word_t          out_data,
    output logic                    running,
    output logic                    halted
);

    logic               ram_we;    // Loader write, gated by mode.
    sap_pkg::load_req_t ram_req;
    logic               start;     // Run accepted.
    logic               halt;      // HLT executed.
    sap_pkg::word_t     in_word;
    sap_pkg::word_t     rdata;     // Word at MAR.
    sap_pkg::word_t     acc;
    sap_pkg::flags_t    flags;
    sap_pkg::ctrl_t     ctrl;
    sap_pkg::addr_t     pc;
    sap_pkg::addr_t     operand;

    program_loader u_loader (
        .clk        (clk),
        .rst        (rst),
        .load_valid (load_valid),
        .load_req   (load_req),
        .run        (run),
        .in_valid   (in_valid),
        .in_data    (in_data),
        .halt       (halt),
        .ram_we     (ram_we),
        .ram_req    (ram_req),
        .start      (start),
        .in_word    (in_word),
        .running    (running),
        .halted     (halted)
    );

    memory_unit u_mem (
        .clk     (clk),
        .rst     (rst),
        .running (running),
        .ext_we  (ram_we),
        .ext_req (ram_req),
        .ctrl    (ctrl),
        .pc      (pc),
        .operand (operand),
        .acc     (acc),
        .rdata   (rdata)
    );

    sequencer u_seq (
        .clk     (clk),
        .rst     (rst),
        .start   (start),
        .rdata   (rdata),
        .flags   (flags),
        .ctrl    (ctrl),
        .pc      (pc),
        .operand (operand),
        .halt    (halt)
    );

    datapath u_dp (
        .clk       (clk),
        .rst       (rst),
        .ctrl      (ctrl),
        .rdata     (rdata),
        .in_word   (in_word),
        .acc       (acc),
        .flags     (flags),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

endmodule

`default_nettype wire

// ==== tests/sap2_mini_chk.sv ====
`default_nettype none

module sap2_mini_chk (
    input wire clk,
    input wire rst,
    input wire out_valid,
    input wire running,
    input wire halted,
    input wire load_valid,
    input wire mem_write,
    input wire ram_we
);

    int violations = 0;  // Failed assertion count.

    // Output strobe is a one-cycle pulse.
    out_valid_single: assert property (
        @(posedge clk) disable iff (rst) out_valid |=> !out_valid
    ) else begin
        violations = violations + 1;
        $error("out_valid stayed high for two cycles");
    end

    // Run and halted modes exclude each other.
    mode_exclusive: assert property (
        @(posedge clk) disable iff (rst) !(running && halted)
    ) else begin
        violations = violations + 1;
        $error("running and halted both high");
    end

    // A loader request never reaches the RAM port during a run.
    load_frozen: assert property (
        @(posedge clk) disable iff (rst) running && load_valid && !mem_write |-> !ram_we
    ) else begin
        violations = violations + 1;
        $error("loader wrote the RAM while running");
    end

endmodule

`default_nettype wire

// ==== tests/sap2_mini_tb.sv ====
`default_nettype none

module sap2_mini_tb;

    localparam int RESET_CYCLES = 10;
    // Worst-case instructions of all runs: 24 + 17 + 29 + 7 + 6 + 10.
    localparam int WORST_INSTR  = 93;
    localparam int MARGIN       = 400;  // Reset, program loads, run pulses.
    localparam int MAX_CYCLES   = WORST_INSTR * 4 + MARGIN;

    logic               clk;
    logic               rst;
    logic               load_valid;
    sap_pkg::load_req_t load_req;
    logic               run;
    logic               in_valid;
    sap_pkg::word_t     in_data;
    logic               out_valid;
    sap_pkg::word_t     out_data;
    logic               running;
    logic               halted;

    sap_pkg::word_t     got_q[$];         // Words seen on the output port.
    sap_pkg::word_t     exp_q[$];         // Words the program must emit.
    int                 cycle_count = 0;

    sap2_mini UUT (
        .clk        (clk),
        .rst        (rst),
        .load_valid (load_valid),
        .load_req   (load_req),
        .run        (run),
        .in_valid   (in_valid),
        .in_data    (in_data),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .running    (running),
        .halted     (halted)
    );

    bind sap2_mini sap2_mini_chk u_chk (
        .clk        (clk),
        .rst        (rst),
        .out_valid  (out_valid),
        .running    (running),
        .halted     (halted),
        .load_valid (load_valid),
        .mem_write  (ctrl.mem_write),
        .ram_we     (u_mem.we)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // Period 4.
    end

    // Registered outputs are stable at the falling edge.
    always @(negedge clk) begin
        if (out_valid) got_q.push_back(out_data);
    end

    // Checker violations end the run at once.
    always @(negedge clk) begin
        if (UUT.u_chk.violations != 0) begin
            $display("Assertion checker flagged %0d violations", UUT.u_chk.violations);
            abort_run();
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > MAX_CYCLES) begin
            $display("Timeout: tests did not finish within %0d cycles", MAX_CYCLES);
            abort_run();
        end
    end

    task automatic abort_run();
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_word(input string what, input sap_pkg::word_t got,
                              input sap_pkg::word_t exp);
        if (got !== exp) begin
            $display("FAIL @%0t: %s got %03h, expected %03h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_flags_state(input string what, input logic exp_running,
                                     input logic exp_halted);
        if (running !== exp_running || halted !== exp_halted) begin
            $display("FAIL @%0t: %s running=%b halted=%b, expected %b %b", $time, what,
                     running, halted, exp_running, exp_halted);
            abort_run();
        end
    endtask

    // Instruction encoders.
    function automatic sap_pkg::word_t mem_op(input sap_pkg::opcode_e op,
                                              input sap_pkg::addr_t addr);
        sap_pkg::instr_t i;
        i.opcode  = op;
        i.operand = addr;
        return sap_pkg::word_t'(i);
    endfunction

    function automatic sap_pkg::word_t opr_op(input sap_pkg::opr_e sub);
        sap_pkg::instr_t i;
        i.opcode  = sap_pkg::OP_OPR;
        i.operand = sub;  // Low byte picks the operate function.
        return sap_pkg::word_t'(i);
    endfunction

    task automatic load_word(input sap_pkg::addr_t addr, input sap_pkg::word_t data);
        @(negedge clk);
        load_valid    = 1'b1;
        load_req.addr = addr;
        load_req.data = data;
        @(negedge clk);
        load_valid = 1'b0;
    endtask

    task automatic pulse_run();
        @(negedge clk);
        run = 1'b1;
        @(negedge clk);
        run = 1'b0;
    endtask

    task automatic wait_halted();
        while (halted !== 1'b1) begin
            @(negedge clk);
        end
    endtask

    task automatic run_program();
        got_q.delete();
        pulse_run();
        check_flags_state("after run", 1'b1, 1'b0);  // Run clears halted.
        wait_halted();
        check_flags_state("after HLT", 1'b0, 1'b1);
    endtask

    task automatic compare_outputs(input string test);
        if (got_q.size() < exp_q.size()) begin
            $display("%s: output word missing, expected %0d words but saw %0d", test,
                     exp_q.size(), got_q.size());
            abort_run();
        end else if (got_q.size() > exp_q.size()) begin
            $display("%s: extra output word, expected %0d words but saw %0d", test,
                     exp_q.size(), got_q.size());
            abort_run();
        end
        foreach (exp_q[i]) begin
            check_word($sformatf("%s word %0d", test, i), got_q[i], exp_q[i]);
        end
        exp_q.delete();
    endtask

    task automatic arithmetic_ops();
        sap_pkg::word_t a;
        sap_pkg::word_t b;
        sap_pkg::word_t c;
        sap_pkg::word_t sum;
        sap_pkg::word_t diff;
        for (int n = 0; n < 4; n++) begin
            a    = sap_pkg::word_t'($urandom);
            b    = sap_pkg::word_t'($urandom);
            c    = sap_pkg::word_t'($urandom);
            sum  = a + b;    // Modulo 2^12.
            diff = sum - c;
            load_word(8'h00, mem_op(sap_pkg::OP_LDA, 8'h80));
            load_word(8'h01, mem_op(sap_pkg::OP_ADD, 8'h81));
            load_word(8'h02, opr_op(sap_pkg::OPR_OUT));
            load_word(8'h03, mem_op(sap_pkg::OP_SUB, 8'h82));
            load_word(8'h04, opr_op(sap_pkg::OPR_OUT));
            load_word(8'h05, opr_op(sap_pkg::OPR_HLT));
            load_word(8'h80, a);
            load_word(8'h81, b);
            load_word(8'h82, c);
            exp_q.push_back(sum);
            exp_q.push_back(diff);
            run_program();
            compare_outputs("arithmetic");
        end
    endtask

    task automatic logic_ops();
        sap_pkg::word_t a;
        sap_pkg::word_t b;
        sap_pkg::word_t nor_val;
        a       = sap_pkg::word_t'($urandom);
        b       = sap_pkg::word_t'($urandom);
        nor_val = ~(a | b);
        for (int k = 0; k < 4; k++) begin
            load_word(sap_pkg::addr_t'(3 * k), mem_op(sap_pkg::OP_LDA, 8'h80));
            load_word(sap_pkg::addr_t'(3 * k + 2), opr_op(sap_pkg::OPR_OUT));
        end
        load_word(8'h01, mem_op(sap_pkg::OP_AND, 8'h81));
        load_word(8'h04, mem_op(sap_pkg::OP_IOR, 8'h81));
        load_word(8'h07, mem_op(sap_pkg::OP_XOR, 8'h81));
        load_word(8'h0A, mem_op(sap_pkg::OP_NOR, 8'h81));
        load_word(8'h0C, opr_op(sap_pkg::OPR_CMA));  // Acc holds the NOR result.
        load_word(8'h0D, opr_op(sap_pkg::OPR_OUT));
        load_word(8'h0E, opr_op(sap_pkg::OPR_CLA));
        load_word(8'h0F, opr_op(sap_pkg::OPR_OUT));
        load_word(8'h10, opr_op(sap_pkg::OPR_HLT));
        load_word(8'h80, a);
        load_word(8'h81, b);
        exp_q.push_back(a & b);
        exp_q.push_back(a | b);
        exp_q.push_back(a ^ b);
        exp_q.push_back(nor_val);
        exp_q.push_back(~nor_val);
        exp_q.push_back(12'h000);
        run_program();
        compare_outputs("logic");
    endtask

    task automatic countdown_branch();
        sap_pkg::word_t n;
        sap_pkg::word_t neg;
        n   = sap_pkg::word_t'(3 + ($urandom % 4));  // Loop count 3 to 6.
        neg = 12'h800 | sap_pkg::word_t'($urandom);  // Sign bit set.
        load_word(8'h00, mem_op(sap_pkg::OP_LDA, 8'h80));
        load_word(8'h01, opr_op(sap_pkg::OPR_OUT));      // Loop top.
        load_word(8'h02, mem_op(sap_pkg::OP_SUB, 8'h81));
        load_word(8'h03, mem_op(sap_pkg::OP_JAZ, 8'h05));
        load_word(8'h04, mem_op(sap_pkg::OP_JMP, 8'h01));
        load_word(8'h05, mem_op(sap_pkg::OP_LDA, 8'h82));
        load_word(8'h06, mem_op(sap_pkg::OP_JAM, 8'h08));
        load_word(8'h07, opr_op(sap_pkg::OPR_OUT));      // Skipped by JAM.
        load_word(8'h08, opr_op(sap_pkg::OPR_CLA));
        load_word(8'h09, opr_op(sap_pkg::OPR_OUT));
        load_word(8'h0A, opr_op(sap_pkg::OPR_HLT));
        load_word(8'h80, n);
        load_word(8'h81, 12'h001);
        load_word(8'h82, neg);
        for (int k = int'(n); k >= 1; k--) begin
            exp_q.push_back(sap_pkg::word_t'(k));
        end
        exp_q.push_back(12'h000);
        run_program();
        compare_outputs("countdown");
    endtask

    task automatic call_return();
        sap_pkg::word_t a;
        sap_pkg::word_t b;
        a = sap_pkg::word_t'($urandom);
        b = sap_pkg::word_t'($urandom);
        load_word(8'h00, mem_op(sap_pkg::OP_LDA, 8'h80));
        load_word(8'h01, mem_op(sap_pkg::OP_CAL, 8'h20));
        load_word(8'h02, mem_op(sap_pkg::OP_LDA, 8'h81));
        load_word(8'h03, opr_op(sap_pkg::OPR_OUT));
        load_word(8'h04, opr_op(sap_pkg::OPR_HLT));
        load_word(8'h20, opr_op(sap_pkg::OPR_OUT));  // Routine body.
        load_word(8'h21, opr_op(sap_pkg::OPR_RET));
        load_word(8'h80, a);
        load_word(8'h81, b);
        exp_q.push_back(a);  // Routine word first.
        exp_q.push_back(b);
        run_program();
        compare_outputs("subroutine");
    endtask

    task automatic input_store();
        sap_pkg::word_t first;
        sap_pkg::word_t second;
        first  = sap_pkg::word_t'($urandom);
        second = sap_pkg::word_t'($urandom);
        load_word(8'h00, opr_op(sap_pkg::OPR_INP));
        load_word(8'h01, mem_op(sap_pkg::OP_STA, 8'h90));
        load_word(8'h02, opr_op(sap_pkg::OPR_CLA));
        load_word(8'h03, mem_op(sap_pkg::OP_LDA, 8'h90));
        load_word(8'h04, opr_op(sap_pkg::OPR_OUT));
        load_word(8'h05, opr_op(sap_pkg::OPR_HLT));
        load_word(8'h90, ~second);  // Stale cell, STA must overwrite.
        @(negedge clk);
        in_valid = 1'b1;
        in_data  = first;
        @(negedge clk);
        in_data = second;           // Last word wins.
        @(negedge clk);
        in_valid = 1'b0;
        exp_q.push_back(second);
        run_program();
        compare_outputs("input and store");
    endtask

    task automatic run_control();
        sap_pkg::word_t a;
        sap_pkg::word_t b;
        a = sap_pkg::word_t'($urandom);
        b = sap_pkg::word_t'($urandom);
        load_word(8'h00, mem_op(sap_pkg::OP_LDA, 8'h80));
        load_word(8'h01, opr_op(sap_pkg::OPR_OUT));
        load_word(8'h02, mem_op(sap_pkg::OP_ADD, 8'h81));
        load_word(8'h03, opr_op(sap_pkg::OPR_OUT));
        load_word(8'h04, opr_op(sap_pkg::OPR_HLT));
        load_word(8'h80, a);
        load_word(8'h81, b);
        got_q.delete();
        pulse_run();
        check_flags_state("control run", 1'b1, 1'b0);
        pulse_run();               // Second run while busy.
        load_word(8'h80, ~a);      // Load while busy.
        wait_halted();
        check_flags_state("control halt", 1'b0, 1'b1);
        exp_q.push_back(a);
        exp_q.push_back(a + b);
        compare_outputs("run while running");
        exp_q.push_back(a);
        exp_q.push_back(a + b);
        run_program();
        compare_outputs("rerun after blocked load");
    endtask

    initial begin
        void'($urandom(62));  // Seed for operands.
        rst        = 1'b1;
        load_valid = 1'b0;
        load_req   = '0;
        run        = 1'b0;
        in_valid   = 1'b0;
        in_data    = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_flags_state("after reset", 1'b0, 1'b0);
        arithmetic_ops();
        logic_ops();
        countdown_branch();
        call_return();
        input_store();
        run_control();
        @(negedge clk);
        if (UUT.u_chk.violations == 0) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            $display("Assertion checker flagged %0d violations", UUT.u_chk.violations);
            abort_run();
        end
    end

endmodule

`default_nettype wire

// ==== sources.f ====
source/sap_pkg.sv
source/program_loader.sv
source/memory_unit.sv
source/alu.sv
source/sequencer.sv
source/datapath.sv
source/sap2_mini.sv
tests/sap2_mini_chk.sv
tests/sap2_mini_tb.sv
